//--- verilog/mdecPkg.sv
// MDEC decode core shared definitions
// Stream widths, block numbers, zigzag order and transform states
package mdecPkg;

	// Data widths with a meaning of their own
	typedef logic [15:0]        streamWord_t;
	typedef logic signed [9:0]  rleVal_t;
	typedef logic [5:0]         scale_t;
	typedef logic signed [11:0] coef_t;
	typedef logic [5:0]         matIdx_t;
	typedef logic [2:0]         blockNum_t;
	typedef logic [6:0]         quant_t;
	typedef logic signed [12:0] cosVal_t;
	typedef logic [7:0]         pixel_t;
	typedef logic [7:0]         pixAddr_t;

	// Block numbering, 0..3 are Y0..Y3
	localparam blockNum_t BLOCK_CR     = 3'd4;
	localparam blockNum_t BLOCK_CB     = 3'd5;
	localparam blockNum_t BLOCK_Y_ONLY = 3'd7;

	// Stream terminator and transform fixed point
	localparam streamWord_t END_CODE = 16'hFE00;
	localparam int          COS_FRAC = 12;

	// Stream position to row-major matrix position
	localparam matIdx_t ZIGZAG [64] = '{
		6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
		6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
		6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
		6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
		6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
		6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
		6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
		6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
	};

	// Transform engine sequencing
	typedef enum logic [1:0] {IDLE, PASS1, PASS2, EMIT} idctState_t;

endpackage

//--- verilog/mdecBus.sv
// Internal buses of the decode core
// Decoded stream coefficients, then dequantized coefficients

interface rleBus import mdecPkg::*; ();
	logic      wrt;
	rleVal_t   value;
	scale_t    scale;
	logic      isDC;
	matIdx_t   matIdx;
	// Linear stream position, quant tables use it
	matIdx_t   seqIdx;
	blockNum_t blockNum;
	logic      blockComplete;

	modport source (output wrt, value, scale, isDC, matIdx, seqIdx, blockNum, blockComplete);
	modport sink (input wrt, value, scale, isDC, matIdx, seqIdx, blockNum, blockComplete);
endinterface

interface coefBus import mdecPkg::*; ();
	logic      wrt;
	matIdx_t   matIdx;
	blockNum_t blockNum;
	coef_t     value;
	// High together with wrt on the end word
	logic      matrixComplete;

	modport source (output wrt, matIdx, blockNum, value, matrixComplete);
	modport sink (input wrt, matIdx, blockNum, value, matrixComplete);
endinterface

//--- verilog/streamDecoder.sv
// Stream decoder
// Splits host words into DC and run-length coefficients, zigzag placed and block numbered
module streamDecoder import mdecPkg::*; (
	input  logic        clk,
	input  logic        i_rst,
	input  logic        i_dataWrite,
	input  streamWord_t i_dataIn,
	input  logic        i_yOnly,
	rleBus.source       rle
);
	logic       firstWord;
	matIdx_t    seqPos;
	scale_t     blockScale;
	blockNum_t  blockCnt;
	logic       isEnd;
	logic [6:0] nextPos;

	// Colour order Cr, Cb, Y0..Y3 then wrap
	function automatic blockNum_t stepBlock(input blockNum_t cur);
		case (cur)
			BLOCK_CR: return BLOCK_CB;
			BLOCK_CB: return 3'd0;
			3'd3:     return BLOCK_CR;
			default:  return cur + 3'd1;
		endcase
	endfunction

	// End code only counts after the DC word
	assign isEnd = !firstWord && (i_dataIn == END_CODE);

	// Run of zeros skipped, then one step for the value itself
	assign nextPos = {1'b0, seqPos} + {1'b0, i_dataIn[15:10]} + 7'd1;

	// ------------------------------
	// Position, block counter, strobes
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			firstWord         <= 1'b1;
			seqPos            <= '0;
			blockCnt          <= BLOCK_CR;
			rle.wrt           <= 1'b0;
			rle.blockComplete <= 1'b0;
		end
		else
		begin
			rle.wrt           <= 1'b0;
			rle.blockComplete <= 1'b0;
			if (i_dataWrite)
			begin
				if (firstWord)
				begin
					// DC sits at position 0
					firstWord <= 1'b0;
					seqPos    <= '0;
					rle.wrt   <= 1'b1;
				end
				else if (isEnd)
				begin
					firstWord         <= 1'b1;
					seqPos            <= '0;
					// Luminance-only stays at 7, counter parked for colour mode
					blockCnt          <= i_yOnly ? BLOCK_CR : stepBlock(blockCnt);
					rle.wrt           <= 1'b1;
					rle.blockComplete <= 1'b1;
				end
				else
				begin
					// Runs past the matrix end are dropped
					seqPos  <= nextPos[6] ? 6'd63 : nextPos[5:0];
					rle.wrt <= !nextPos[6];
				end
			end
		end
	end

	// ------------------------------
	// Coefficient payload
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (i_dataWrite)
		begin
			rle.value    <= i_dataIn[9:0];
			rle.isDC     <= firstWord;
			rle.scale    <= firstWord ? i_dataIn[15:10] : blockScale;
			rle.seqIdx   <= firstWord ? 6'd0 : nextPos[5:0];
			rle.matIdx   <= firstWord ? ZIGZAG[0] : ZIGZAG[nextPos[5:0]];
			rle.blockNum <= i_yOnly ? BLOCK_Y_ONLY : blockCnt;
			if (firstWord)
			begin
				// Scale held for the AC words of this block
				blockScale <= i_dataIn[15:10];
			end
		end
	end

endmodule

//--- verilog/coefDequant.sv
// Coefficient dequantizer
// Scales DC and AC values by the loaded quant tables, clamped to coefficient range
module coefDequant import mdecPkg::*; (
	input  logic        clk,
	input  logic        i_rst,
	input  logic        i_quantWrt,
	input  logic [27:0] i_quantValue,
	input  logic [3:0]  i_quantAdr,
	input  logic        i_quantTblSelect,
	rleBus.sink         rle,
	coefBus.source      coef
);
	// Table 0 luminance, table 1 chroma
	quant_t             quantTbl [2][64];
	logic               tblSel;
	quant_t             qDc;
	quant_t             qAc;
	logic signed [24:0] prodDc;
	logic signed [24:0] prodAc;
	logic signed [24:0] scaled;
	logic signed [24:0] result;

	function automatic coef_t clampCoef(input logic signed [24:0] v);
		if (v > 25'sd2047)
			return 12'sd2047;
		if (v < -25'sd2048)
			return -12'sd2048;
		return v[11:0];
	endfunction

	// Four 7-bit steps per write, lowest field first
	always_ff @(posedge clk)
	begin
		if (i_quantWrt)
		begin
			for (int i = 0; i < 4; i++)
			begin
				quantTbl[i_quantTblSelect][{i_quantAdr, 2'(i)}] <= i_quantValue[i*7 +: 7];
			end
		end
	end

	assign tblSel = (rle.blockNum == BLOCK_CR) || (rle.blockNum == BLOCK_CB);
	assign qDc    = quantTbl[tblSel][0];
	// AC step is looked up in stream order
	assign qAc    = quantTbl[tblSel][rle.seqIdx];

	assign prodDc = rle.value * $signed({1'b0, qDc});
	assign prodAc = rle.value * $signed({1'b0, qAc}) * $signed({1'b0, rle.scale});
	// Rounded divide by 8
	assign scaled = (prodAc + 25'sd4) >>> 3;
	assign result = rle.isDC ? prodDc : scaled;

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			coef.wrt            <= 1'b0;
			coef.matrixComplete <= 1'b0;
		end
		else
		begin
			coef.wrt            <= rle.wrt;
			coef.matrixComplete <= rle.wrt && rle.blockComplete;
		end
	end

	always_ff @(posedge clk)
	begin
		coef.matIdx   <= rle.matIdx;
		coef.blockNum <= rle.blockNum;
		coef.value    <= clampCoef(result);
	end

endmodule

//--- verilog/idctCore.sv
// Inverse DCT core
// Double-banked coefficient store with a two-pass multiply-accumulate transform
module idctCore import mdecPkg::*; (
	input  logic        clk,
	input  logic        i_rst,
	coefBus.sink        coef,
	output logic        o_canLoad,
	input  logic        i_cosWrite,
	input  logic [4:0]  i_cosIndex,
	input  logic [25:0] i_cosVal,
	input  logic        i_pause,
	output logic        o_valueWrt,
	output pixel_t      o_value,
	output matIdx_t     o_valueIdx,
	output blockNum_t   o_blockNum,
	output logic        o_busy
);
	coef_t              bank [2][64];
	// Per-entry written flags, unwritten entries read as zero
	logic [1:0][63:0]   written;
	logic [1:0]         full;
	blockNum_t          bankBlk [2];
	logic               loadSel;
	logic               loadFresh;
	logic               xfSel;

	cosVal_t            cosTbl [64];
	logic signed [15:0] midBuf [64];
	pixel_t             outBuf [64];

	idctState_t         state;
	// Loop counter as {outer, x, tap}
	logic [8:0]         cnt;
	logic signed [31:0] acc;
	logic signed [31:0] accNext;
	logic signed [31:0] prod;
	logic signed [15:0] dataOp;
	cosVal_t            cosOp;
	matIdx_t            coefAdr;
	logic signed [19:0] shifted;
	logic               lastTap;
	logic               coefIn;

	function automatic pixel_t clampPix(input logic signed [19:0] v);
		if (v > 20'sd127)
			return 8'h7F;
		if (v < -20'sd128)
			return 8'h80;
		return v[7:0];
	endfunction

	assign coefIn = coef.wrt && !coef.matrixComplete;

	// ------------------------------
	// Loading side
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (coefIn)
			bank[loadSel][coef.matIdx] <= coef.value;
		if (coef.wrt && coef.matrixComplete)
			bankBlk[loadSel] <= coef.blockNum;
		if (i_cosWrite)
		begin
			// Two table entries per write, low half first
			cosTbl[{i_cosIndex, 1'b0}] <= i_cosVal[12:0];
			cosTbl[{i_cosIndex, 1'b1}] <= i_cosVal[25:13];
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			written   <= '0;
			full      <= '0;
			loadSel   <= 1'b0;
			loadFresh <= 1'b1;
		end
		else
		begin
			if (coefIn)
			begin
				// First coefficient of a block wipes the old flags
				written[loadSel] <= (loadFresh ? 64'd0 : written[loadSel]) |
					(64'd1 << coef.matIdx);
				loadFresh <= 1'b0;
			end
			else if (coef.wrt && coef.matrixComplete)
			begin
				if (loadFresh)
					written[loadSel] <= '0;
				full[loadSel] <= 1'b1;
				loadSel       <= !loadSel;
				loadFresh     <= 1'b1;
			end
			// Bank is free once pass 1 has read it
			if (state == PASS1 && cnt == 9'd511)
				full[xfSel] <= 1'b0;
		end
	end

	// Other bank still waiting or in pass 1 stops the host
	assign o_canLoad = !full[!loadSel];

	// ------------------------------
	// Multiply-accumulate datapath
	// ------------------------------
	// Pass 1 reads coef(v,u), pass 2 reads mid(v,x)
	assign coefAdr = (state == PASS1) ? {cnt[8:6], cnt[2:0]} : {cnt[2:0], cnt[5:3]};

	always_comb
	begin
		if (state == PASS1)
		begin
			// Factor for frequency u at position x
			cosOp = cosTbl[{cnt[2:0], cnt[5:3]}];
			if (written[xfSel][coefAdr])
				dataOp = 16'(bank[xfSel][coefAdr]);
			else
				dataOp = '0;
		end
		else
		begin
			// Factor for frequency v at position y
			cosOp  = cosTbl[{cnt[2:0], cnt[8:6]}];
			dataOp = midBuf[coefAdr];
		end
	end

	assign prod    = dataOp * cosOp;
	assign accNext = acc + prod;
	assign shifted = 20'(accNext >>> COS_FRAC);
	assign lastTap = (cnt[2:0] == 3'd7);

	always_ff @(posedge clk)
	begin
		if (state == PASS1 && lastTap)
			midBuf[cnt[8:3]] <= shifted[15:0];
		if (state == PASS2 && lastTap)
			outBuf[cnt[8:3]] <= clampPix(shifted);
	end

	// ------------------------------
	// Engine FSM
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			state      <= IDLE;
			cnt        <= '0;
			acc        <= '0;
			xfSel      <= 1'b0;
			o_blockNum <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					cnt <= '0;
					acc <= '0;
					if (full[xfSel])
					begin
						o_blockNum <= bankBlk[xfSel];
						state      <= PASS1;
					end
				end
				PASS1, PASS2:
				begin
					cnt <= cnt + 9'd1;
					acc <= lastTap ? 32'sd0 : accNext;
					if (cnt == 9'd511)
					begin
						state <= (state == PASS1) ? PASS2 : EMIT;
						if (state == PASS1)
							xfSel <= !xfSel;
					end
				end
				EMIT:
				begin
					// Counter wrapped to 0 on the way in
					if (!i_pause)
					begin
						cnt <= cnt + 9'd1;
						if (cnt[5:0] == 6'd63)
							state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	assign o_valueWrt = (state == EMIT) && !i_pause;
	assign o_value    = outBuf[cnt[5:0]];
	assign o_valueIdx = cnt[5:0];
	assign o_busy     = (state != IDLE);

endmodule

//--- verilog/colorConvert.sv
// Colour converter
// Turns luminance plus chroma into clamped RGB components with pixel addresses
module colorConvert import mdecPkg::*; (
	input  logic        clk,
	input  logic        i_rst,
	input  logic        i_wrt,
	input  logic        i_yOnly,
	input  logic        i_signed,
	input  matIdx_t     i_writeIdx,
	input  pixel_t      i_valueY,
	input  logic [1:0]  i_yBlockNum,
	output matIdx_t     o_readAdr,
	input  pixel_t      i_valueCr,
	input  pixel_t      i_valueCb,
	output logic        o_wPix,
	output pixAddr_t    o_pix,
	output pixel_t      o_r,
	output pixel_t      o_g,
	output pixel_t      o_b
);
	logic [3:0]         row;
	logic [3:0]         col;
	logic               wrt1;
	logic               yOnly1;
	pixel_t             y1;
	pixAddr_t           pix1;
	logic signed [19:0] yS;
	logic signed [19:0] crS;
	logic signed [19:0] cbS;
	logic signed [19:0] rSum;
	logic signed [19:0] gSum;
	logic signed [19:0] bSum;

	// Clamp to a signed byte, top bit flipped for the unsigned format
	function automatic pixel_t finishPix(input logic signed [19:0] v, input logic sgn);
		pixel_t p;
		if (v > 20'sd127)
			p = 8'h7F;
		else if (v < -20'sd128)
			p = 8'h80;
		else
			p = v[7:0];
		return {p[7] ^ !sgn, p[6:0]};
	endfunction

	// Position inside the 16x16 macroblock, Y1 right and Y2 below
	assign row = {i_yBlockNum[1], i_writeIdx[5:3]};
	assign col = {i_yBlockNum[0], i_writeIdx[2:0]};

	// Chroma is subsampled by two both ways
	assign o_readAdr = {row[3:1], col[3:1]};

	// ------------------------------
	// Stage 1, chroma read in flight
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
			wrt1 <= 1'b0;
		else
			wrt1 <= i_wrt;
	end

	always_ff @(posedge clk)
	begin
		y1     <= i_valueY;
		yOnly1 <= i_yOnly;
		// 8x8 grey block uses [0yyy0xxx]
		pix1   <= i_yOnly ? {1'b0, i_writeIdx[5:3], 1'b0, i_writeIdx[2:0]} : {row, col};
	end

	assign yS  = $signed(y1);
	assign crS = $signed(i_valueCr);
	assign cbS = $signed(i_valueCb);

	assign rSum = yS + ((20'sd359 * crS) >>> 8);
	assign gSum = yS - ((20'sd88 * cbS + 20'sd183 * crS) >>> 8);
	assign bSum = yS + ((20'sd454 * cbS) >>> 8);

	// ------------------------------
	// Stage 2, registered pixel
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
			o_wPix <= 1'b0;
		else
			o_wPix <= wrt1;
	end

	always_ff @(posedge clk)
	begin
		o_pix <= pix1;
		o_r   <= finishPix(yOnly1 ? yS : rSum, i_signed);
		o_g   <= finishPix(yOnly1 ? yS : gSum, i_signed);
		o_b   <= finishPix(yOnly1 ? yS : bSum, i_signed);
	end

endmodule

//--- verilog/mdecCore.sv
// MDEC decode core top level
// Stream decode, dequantize, inverse DCT and colour conversion with chroma storage
module mdecCore import mdecPkg::*; (
	input  logic        clk,
	input  logic        i_rst,
	input  logic [1:0]  i_bitSetupDepth,
	input  logic        i_bitSigned,
	input  logic        i_dataWrite,
	input  streamWord_t i_dataIn,
	output logic        o_endMatrix,
	output logic        o_allowLoad,
	input  logic        i_cosWrite,
	input  logic [4:0]  i_cosIndex,
	input  logic [25:0] i_cosVal,
	input  logic        i_quantWrt,
	input  logic [27:0] i_quantValue,
	input  logic [3:0]  i_quantAdr,
	input  logic        i_quantTblSelect,
	input  logic        i_stopFillY,
	output blockNum_t   o_idctBlockNum,
	output logic        o_stillIDCT,
	output logic        o_pixelOut,
	output pixAddr_t    o_pixelAddress,
	output pixel_t      o_rComp,
	output pixel_t      o_gComp,
	output pixel_t      o_bComp
);
	rleBus  rleIf ();
	coefBus coefIf ();

	logic      yOnly;
	logic      valueWrt;
	pixel_t    value;
	matIdx_t   valueIdx;
	blockNum_t valueBlk;
	logic      isYOnlyBlock;
	logic      isYBlock;
	logic      pauseY;
	matIdx_t   readAdr;
	matIdx_t   readAdrReg;
	pixel_t    crMem [64];
	pixel_t    cbMem [64];

	// Depth 0 and 1 are the grey formats
	assign yOnly = !i_bitSetupDepth[1];

	streamDecoder streamDecoderInst (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_dataWrite (i_dataWrite),
		.i_dataIn    (i_dataIn),
		.i_yOnly     (yOnly),
		.rle         (rleIf)
	);

	assign o_endMatrix = rleIf.wrt && rleIf.blockComplete;

	coefDequant coefDequantInst (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_quantWrt       (i_quantWrt),
		.i_quantValue     (i_quantValue),
		.i_quantAdr       (i_quantAdr),
		.i_quantTblSelect (i_quantTblSelect),
		.rle              (rleIf),
		.coef             (coefIf)
	);

	idctCore idctCoreInst (
		.clk        (clk),
		.i_rst      (i_rst),
		.coef       (coefIf),
		.o_canLoad  (o_allowLoad),
		.i_cosWrite (i_cosWrite),
		.i_cosIndex (i_cosIndex),
		.i_cosVal   (i_cosVal),
		.i_pause    (pauseY),
		.o_valueWrt (valueWrt),
		.o_value    (value),
		.o_valueIdx (valueIdx),
		.o_blockNum (valueBlk),
		.o_busy     (o_stillIDCT)
	);

	assign o_idctBlockNum = valueBlk;

	// Y0..Y3 or the single grey block
	assign isYOnlyBlock = (valueBlk == BLOCK_Y_ONLY);
	assign isYBlock     = isYOnlyBlock || !valueBlk[2];
	// Output FIFO near full holds back luminance only
	assign pauseY       = isYBlock && i_stopFillY;

	// ------------------------------
	// Cr and Cb memories, 8x8 each
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (valueWrt && valueBlk == BLOCK_CR)
			crMem[valueIdx] <= value;
		if (valueWrt && valueBlk == BLOCK_CB)
			cbMem[valueIdx] <= value;
		readAdrReg <= readAdr;
	end

	colorConvert colorConvertInst (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_wrt       (valueWrt && isYBlock),
		.i_yOnly     (isYOnlyBlock),
		.i_signed    (i_bitSigned),
		.i_writeIdx  (valueIdx),
		.i_valueY    (value),
		.i_yBlockNum (valueBlk[1:0]),
		.o_readAdr   (readAdr),
		.i_valueCr   (crMem[readAdrReg]),
		.i_valueCb   (cbMem[readAdrReg]),
		.o_wPix      (o_pixelOut),
		.o_pix       (o_pixelAddress),
		.o_r         (o_rComp),
		.o_g         (o_gComp),
		.o_b         (o_bComp)
	);

endmodule

//--- bench/clockGen.sv
// Testbench clock and reset source
// 20 ns clock, reset held high for the first 3 cycles
module clockGen (
	output logic clk,
	output logic o_rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		o_rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		o_rst = 1'b0;
	end

endmodule

//--- bench/mdecTb.sv
// MDEC decode core testbench
// Random run-length blocks against a reference model, scoreboard keyed by pixel address
module mdecTb import mdecPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int Q_LUMA   = 2;
	localparam int Q_CHROMA = 3;

	logic        clk;
	logic        rst;
	logic [1:0]  i_bitSetupDepth;
	logic        i_bitSigned;
	logic        i_dataWrite;
	streamWord_t i_dataIn;
	logic        i_cosWrite;
	logic [4:0]  i_cosIndex;
	logic [25:0] i_cosVal;
	logic        i_quantWrt;
	logic [27:0] i_quantValue;
	logic [3:0]  i_quantAdr;
	logic        i_quantTblSelect;
	logic        i_stopFillY;
	logic        o_endMatrix;
	logic        o_allowLoad;
	blockNum_t   o_idctBlockNum;
	logic        o_stillIDCT;
	logic        o_pixelOut;
	pixAddr_t    o_pixelAddress;
	pixel_t      o_rComp;
	pixel_t      o_gComp;
	pixel_t      o_bComp;

	// Bookkeeping
	int          errCount;
	int          pixCount;
	int          wordCount;
	int          endWords;
	int          endSeen;
	logic [31:0] rngState;
	logic [31:0] stopState;
	logic        stopRandom;

	// Block numbers in stream order, popped as each transform starts
	blockNum_t   expBlk [$];
	logic        stillPrev;

	// Scoreboard
	logic        expValid [256];
	logic        seen [256];
	pixel_t      expR [256];
	pixel_t      expG [256];
	pixel_t      expB [256];
	int          expCnt;
	int          seenCnt;

	// Current block and its model output
	int          blkDc;
	int          blkScale;
	int          blkLen;
	int          blkRun [64];
	int          blkVal [64];
	int          modelPix [64];
	int          crPix [64];
	int          cbPix [64];

	clockGen clockGenInst (
		.clk   (clk),
		.o_rst (rst)
	);

	mdecCore i_dut (
		.clk              (clk),
		.i_rst            (rst),
		.i_bitSetupDepth  (i_bitSetupDepth),
		.i_bitSigned      (i_bitSigned),
		.i_dataWrite      (i_dataWrite),
		.i_dataIn         (i_dataIn),
		.o_endMatrix      (o_endMatrix),
		.o_allowLoad      (o_allowLoad),
		.i_cosWrite       (i_cosWrite),
		.i_cosIndex       (i_cosIndex),
		.i_cosVal         (i_cosVal),
		.i_quantWrt       (i_quantWrt),
		.i_quantValue     (i_quantValue),
		.i_quantAdr       (i_quantAdr),
		.i_quantTblSelect (i_quantTblSelect),
		.i_stopFillY      (i_stopFillY),
		.o_idctBlockNum   (o_idctBlockNum),
		.o_stillIDCT      (o_stillIDCT),
		.o_pixelOut       (o_pixelOut),
		.o_pixelAddress   (o_pixelAddress),
		.o_rComp          (o_rComp),
		.o_gComp          (o_gComp),
		.o_bComp          (o_bComp)
	);

	// ------------------------------
	// Random numbers and model rules
	// ------------------------------
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		rngState = lcgNext(rngState);
		return lo + int'((rngState >> 8) % (hi - lo + 1));
	endfunction

	function automatic int clampRange(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// Signed byte, offset by 128 when unsigned
	function automatic pixel_t toComp(input int v, input logic sgn);
		pixel_t p;
		p = 8'(clampRange(v, -128, 127));
		return sgn ? p : (p ^ 8'h80);
	endfunction

	// Dequant, zigzag, identity IDCT (divide by 4) and clamp
	task automatic modelBlock(input logic isChroma);
		int coefM [64];
		int q;
		int pos;
		int c;
		q   = isChroma ? Q_CHROMA : Q_LUMA;
		pos = 0;
		for (int i = 0; i < 64; i++)
			coefM[i] = 0;
		coefM[ZIGZAG[0]] = clampRange(blkDc * q, -2048, 2047);
		for (int i = 0; i < blkLen; i++)
		begin
			pos = pos + blkRun[i] + 1;
			c   = (blkVal[i] * q * blkScale + 4) >>> 3;
			coefM[ZIGZAG[pos]] = clampRange(c, -2048, 2047);
		end
		for (int i = 0; i < 64; i++)
			modelPix[i] = clampRange((coefM[i] >>> 1) >>> 1, -128, 127);
	endtask

	task automatic genBlock(input int maxAbs, input int scaleMax, input int acMax);
		int n;
		int pos;
		int run;
		blkDc    = randRange(-maxAbs, maxAbs - 1);
		blkScale = randRange(1, scaleMax);
		n        = randRange(0, acMax);
		pos      = 0;
		blkLen   = 0;
		while (blkLen < n)
		begin
			run = randRange(0, 4);
			if (pos + run + 1 > 63)
				break;
			pos            = pos + run + 1;
			blkRun[blkLen] = run;
			blkVal[blkLen] = randRange(-maxAbs, maxAbs - 1);
			blkLen++;
		end
	endtask

	// ------------------------------
	// Host side drivers
	// ------------------------------
	// Called 2 ns after an edge, holds off while the core is full
	task automatic sendWord(input streamWord_t w);
		while (!o_allowLoad)
		begin
			@(posedge clk);
			#2;
		end
		i_dataWrite = 1'b1;
		i_dataIn    = w;
		wordCount++;
		@(posedge clk);
		#2;
		i_dataWrite = 1'b0;
	endtask

	task automatic sendBlock(input blockNum_t blk);
		expBlk.push_back(blk);
		sendWord({6'(blkScale), 10'(blkDc)});
		for (int i = 0; i < blkLen; i++)
			sendWord({6'(blkRun[i]), 10'(blkVal[i])});
		sendWord(END_CODE);
		endWords++;
	endtask

	task automatic loadTables();
		// Identity cosine, 2048 where frequency equals position
		for (int i = 0; i < 32; i++)
		begin
			i_cosWrite = 1'b1;
			i_cosIndex = 5'(i);
			i_cosVal   = '0;
			if ((2 * i) / 8 == (2 * i) % 8)
				i_cosVal[12:0] = 13'd2048;
			if ((2 * i + 1) / 8 == (2 * i + 1) % 8)
				i_cosVal[25:13] = 13'd2048;
			@(posedge clk);
			#2;
		end
		i_cosWrite = 1'b0;
		for (int t = 0; t < 2; t++)
		begin
			for (int a = 0; a < 16; a++)
			begin
				i_quantWrt       = 1'b1;
				i_quantTblSelect = t[0];
				i_quantAdr       = 4'(a);
				i_quantValue     = {4{7'(t == 0 ? Q_LUMA : Q_CHROMA)}};
				@(posedge clk);
				#2;
			end
		end
		i_quantWrt = 1'b0;
	endtask

	// ------------------------------
	// Scoreboard
	// ------------------------------
	task automatic clearBoard();
		for (int a = 0; a < 256; a++)
		begin
			expValid[a] = 1'b0;
			seen[a]     = 1'b0;
		end
		expCnt  = 0;
		seenCnt = 0;
	endtask

	task automatic expectPix(input int a, input int r, input int g, input int b);
		expValid[a] = 1'b1;
		expR[a]     = toComp(r, i_bitSigned);
		expG[a]     = toComp(g, i_bitSigned);
		expB[a]     = toComp(b, i_bitSigned);
		expCnt++;
	endtask

	task automatic checkPixel();
		int a;
		a = int'(o_pixelAddress);
		pixCount++;
		assert (expValid[a])
		else
		begin
			errCount++;
			$display("Pixel at unexpected address %h", o_pixelAddress);
		end
		assert (!seen[a])
		else
		begin
			errCount++;
			$display("Pixel address %h delivered twice", o_pixelAddress);
		end
		assert (o_rComp == expR[a])
		else
		begin
			errCount++;
			$display("CHECK FAILED o_rComp @%h: got %h, expected %h", a, o_rComp, expR[a]);
		end
		assert (o_gComp == expG[a])
		else
		begin
			errCount++;
			$display("CHECK FAILED o_gComp @%h: got %h, expected %h", a, o_gComp, expG[a]);
		end
		assert (o_bComp == expB[a])
		else
		begin
			errCount++;
			$display("CHECK FAILED o_bComp @%h: got %h, expected %h", a, o_bComp, expB[a]);
		end
		if (expValid[a] && !seen[a])
			seenCnt++;
		seen[a] = 1'b1;
	endtask

	// Transforms start in stream order, Cr Cb Y0..Y3 or the grey block 7
	task automatic checkBlockNum();
		blockNum_t want;
		assert (expBlk.size() != 0)
		else
		begin
			errCount++;
			$display("Transform started with no block pending");
		end
		if (expBlk.size() != 0)
		begin
			want = expBlk.pop_front();
			assert (o_idctBlockNum == want)
			else
			begin
				errCount++;
				$display("CHECK FAILED o_idctBlockNum: got %h, expected %h",
					o_idctBlockNum, want);
			end
		end
	endtask

	// Pixels sampled at the edge, before the core updates them
	always @(posedge clk)
	begin
		if (!rst && o_pixelOut)
			checkPixel();
		if (!rst && o_endMatrix)
			endSeen++;
		// Busy rising marks a new block entering the transform
		if (!rst && o_stillIDCT && !stillPrev)
			checkBlockNum();
		stillPrev = o_stillIDCT;
	end

	// Wait for every expected pixel, then let stragglers show up
	task automatic drainPixels();
		while (seenCnt < expCnt)
			@(posedge clk);
		while (o_stillIDCT)
			@(posedge clk);
		repeat (8) @(posedge clk);
		#2;
		assert (endSeen == endWords)
		else
		begin
			errCount++;
			$display("CHECK FAILED o_endMatrix count: got %h, expected %h", endSeen, endWords);
		end
	endtask

	// A paused Y block must not reach the pixel output
	assert property (@(posedge clk) disable iff (rst) o_pixelOut |-> !$past(i_stopFillY, 2))
	else
	begin
		errCount++;
		$display("Pixel delivered while the output FIFO was near full");
	end

	// ------------------------------
	// Test sequences
	// ------------------------------
	task automatic runGrey(input logic sgn, input int maxAbs, input int scaleMax, input int acMax);
		i_bitSetupDepth = 2'd0;
		i_bitSigned     = sgn;
		genBlock(maxAbs, scaleMax, acMax);
		modelBlock(1'b0);
		clearBoard();
		// Grey layout [0 row 0 col]
		for (int i = 0; i < 64; i++)
			expectPix((i / 8) * 16 + (i % 8), modelPix[i], modelPix[i], modelPix[i]);
		sendBlock(BLOCK_Y_ONLY);
		drainPixels();
	endtask

	task automatic runColour(input logic sgn);
		int row;
		int col;
		int c;
		i_bitSetupDepth = 2'd2;
		i_bitSigned     = sgn;
		clearBoard();
		genBlock(64, 15, 12);
		modelBlock(1'b1);
		crPix = modelPix;
		sendBlock(BLOCK_CR);
		genBlock(64, 15, 12);
		modelBlock(1'b1);
		cbPix = modelPix;
		sendBlock(BLOCK_CB);
		for (int b = 0; b < 4; b++)
		begin
			genBlock(64, 15, 12);
			modelBlock(1'b0);
			for (int i = 0; i < 64; i++)
			begin
				row = (b / 2) * 8 + i / 8;
				col = (b % 2) * 8 + i % 8;
				// Chroma at half the pixel coordinates
				c = (row / 2) * 8 + col / 2;
				expectPix(row * 16 + col,
					modelPix[i] + ((359 * crPix[c]) >>> 8),
					modelPix[i] - ((88 * cbPix[c] + 183 * crPix[c]) >>> 8),
					modelPix[i] + ((454 * cbPix[c]) >>> 8));
			end
			sendBlock(3'(b));
		end
		drainPixels();
	endtask

	// Random near-full pattern while enabled
	always @(posedge clk)
	begin
		#2;
		if (stopRandom)
		begin
			stopState   = lcgNext(stopState);
			i_stopFillY = stopState[17];
		end
		else
			i_stopFillY = 1'b0;
	end

	// Limit grows with the stream length, each block adds a full two-pass transform
	initial
	begin
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles > wordCount * 40 + endWords * 2000 + 20000)
			begin
				$display("Watchdog expired after %0d cycles, %0d words sent", cycles, wordCount);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	initial
	begin
		errCount         = 0;
		pixCount         = 0;
		wordCount        = 0;
		endWords         = 0;
		endSeen          = 0;
		stillPrev        = 1'b0;
		rngState         = 32'h82a4_515a;
		stopState        = lcgNext(32'h82a4_515a);
		stopRandom       = 1'b0;
		i_bitSetupDepth  = 2'd0;
		i_bitSigned      = 1'b1;
		i_dataWrite      = 1'b0;
		i_dataIn         = '0;
		i_cosWrite       = 1'b0;
		i_cosIndex       = '0;
		i_cosVal         = '0;
		i_quantWrt       = 1'b0;
		i_quantValue     = '0;
		i_quantAdr       = '0;
		i_quantTblSelect = 1'b0;
		i_stopFillY      = 1'b0;
		clearBoard();

		// Reset drops 2 ns after its last edge
		@(negedge rst);
		assert (!o_pixelOut && !o_endMatrix && !o_stillIDCT && o_allowLoad)
		else
		begin
			errCount++;
			$display("Outputs not at their idle levels after reset");
		end

		loadTables();
		// DC-only grey blocks
		for (int k = 0; k < 4; k++)
			runGrey(1'b1, 256, 15, 0);
		// Random run-length grey blocks
		for (int k = 0; k < 8; k++)
			runGrey(1'b1, 64, 15, 20);
		// Large values clamp, signed and unsigned
		for (int k = 0; k < 4; k++)
			runGrey(k[0], 512, 63, 20);
		// Colour macroblocks
		runColour(1'b1);
		runColour(1'b0);
		// Back-pressure on Y output
		stopRandom = 1'b1;
		for (int k = 0; k < 3; k++)
			runColour(k[0]);
		stopRandom = 1'b0;

		$display("Errors: %0d, pixels checked: %0d, blocks: %0d", errCount, pixCount, endWords);
		if (errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- list.f
verilog/mdecPkg.sv
verilog/mdecBus.sv
verilog/streamDecoder.sv
verilog/coefDequant.sv
verilog/idctCore.sv
verilog/colorConvert.sv
verilog/mdecCore.sv
bench/clockGen.sv
bench/mdecTb.sv

//--- run.sh
#!/bin/sh
# Builds the MDEC decode core testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module mdecTb \
	-f list.f

./obj_dir/VmdecTb | tee sim.log

# The run passes only when the testbench printed its pass line
grep -q "^Simulation finished: PASS$" sim.log
